/* narrow_wide_router.f */
noc_router_pkg.sv
vc_input_port.sv
output_port_alloc.sv
vc_router.sv
narrow_wide_router.sv
tb_narrow_wide_router.sv

/* narrow_wide_router.sv */
// Router tile with separate req, rsp and wide networks; XY routing and one local port only
module narrow_wide_router (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  input  noc_router_pkg::coord_t                                    tile_id_i,
  input  noc_router_pkg::req_link_t  [noc_router_pkg::NumPorts-1:0] req_i,
  output noc_router_pkg::req_link_t  [noc_router_pkg::NumPorts-1:0] req_o,
  input  noc_router_pkg::rsp_link_t  [noc_router_pkg::NumPorts-1:0] rsp_i,
  output noc_router_pkg::rsp_link_t  [noc_router_pkg::NumPorts-1:0] rsp_o,
  input  noc_router_pkg::wide_link_t [noc_router_pkg::NumPorts-1:0] wide_i,
  output noc_router_pkg::wide_link_t [noc_router_pkg::NumPorts-1:0] wide_o
);
  import noc_router_pkg::*;

  logic      [NumPorts-1:0] req_v_in;
  logic      [NumPorts-1:0] req_v_out;
  logic      [NumPorts-1:0] req_cv_in;
  logic      [NumPorts-1:0] req_cv_out;
  vc_id_t    [NumPorts-1:0] req_cid_in;
  vc_id_t    [NumPorts-1:0] req_cid_out;
  flit_hdr_t [NumPorts-1:0] req_hdr_in;
  flit_hdr_t [NumPorts-1:0] req_hdr_out;
  logic      [NumPorts-1:0][NarrowPayloadWidth-1:0] req_pl_in;
  logic      [NumPorts-1:0][NarrowPayloadWidth-1:0] req_pl_out;

  logic      [NumPorts-1:0] rsp_v_in;
  logic      [NumPorts-1:0] rsp_v_out;
  logic      [NumPorts-1:0] rsp_cv_in;
  logic      [NumPorts-1:0] rsp_cv_out;
  vc_id_t    [NumPorts-1:0] rsp_cid_in;
  vc_id_t    [NumPorts-1:0] rsp_cid_out;
  flit_hdr_t [NumPorts-1:0] rsp_hdr_in;
  flit_hdr_t [NumPorts-1:0] rsp_hdr_out;
  logic      [NumPorts-1:0][NarrowPayloadWidth-1:0] rsp_pl_in;
  logic      [NumPorts-1:0][NarrowPayloadWidth-1:0] rsp_pl_out;

  logic      [NumPorts-1:0] wide_v_in;
  logic      [NumPorts-1:0] wide_v_out;
  logic      [NumPorts-1:0] wide_cv_in;
  logic      [NumPorts-1:0] wide_cv_out;
  vc_id_t    [NumPorts-1:0] wide_cid_in;
  vc_id_t    [NumPorts-1:0] wide_cid_out;
  flit_hdr_t [NumPorts-1:0] wide_hdr_in;
  flit_hdr_t [NumPorts-1:0] wide_hdr_out;
  logic      [NumPorts-1:0][WidePayloadWidth-1:0] wide_pl_in;
  logic      [NumPorts-1:0][WidePayloadWidth-1:0] wide_pl_out;

  // Split each link into flit strobes toward the router and credit strobes back
  for (genvar i = 0; i < NumPorts; i++) begin : gen_split
    assign req_v_in[i]    = req_i[i].valid;
    assign req_hdr_in[i]  = req_i[i].hdr;
    assign req_pl_in[i]   = req_i[i].payload;
    assign req_cv_in[i]   = req_i[i].credit_v;
    assign req_cid_in[i]  = req_i[i].credit_id;
    assign req_o[i]       = '{req_v_out[i], req_hdr_out[i], req_pl_out[i],
                              req_cv_out[i], req_cid_out[i]};

    assign rsp_v_in[i]    = rsp_i[i].valid;
    assign rsp_hdr_in[i]  = rsp_i[i].hdr;
    assign rsp_pl_in[i]   = rsp_i[i].payload;
    assign rsp_cv_in[i]   = rsp_i[i].credit_v;
    assign rsp_cid_in[i]  = rsp_i[i].credit_id;
    assign rsp_o[i]       = '{rsp_v_out[i], rsp_hdr_out[i], rsp_pl_out[i],
                              rsp_cv_out[i], rsp_cid_out[i]};

    assign wide_v_in[i]   = wide_i[i].valid;
    assign wide_hdr_in[i] = wide_i[i].hdr;
    assign wide_pl_in[i]  = wide_i[i].payload;
    assign wide_cv_in[i]  = wide_i[i].credit_v;
    assign wide_cid_in[i] = wide_i[i].credit_id;
    assign wide_o[i]      = '{wide_v_out[i], wide_hdr_out[i], wide_pl_out[i],
                              wide_cv_out[i], wide_cid_out[i]};
  end

  vc_router #(
    .PayloadWidth (NarrowPayloadWidth)
  ) i_req_vc_router (
    .clk_i,
    .rst_n_i,
    .tile_id_i,
    .data_valid_i   (req_v_in),
    .data_hdr_i     (req_hdr_in),
    .data_payload_i (req_pl_in),
    .credit_valid_i (req_cv_in),
    .credit_id_i    (req_cid_in),
    .data_valid_o   (req_v_out),
    .data_hdr_o     (req_hdr_out),
    .data_payload_o (req_pl_out),
    .credit_valid_o (req_cv_out),
    .credit_id_o    (req_cid_out)
  );

  vc_router #(
    .PayloadWidth (NarrowPayloadWidth)
  ) i_rsp_vc_router (
    .clk_i,
    .rst_n_i,
    .tile_id_i,
    .data_valid_i   (rsp_v_in),
    .data_hdr_i     (rsp_hdr_in),
    .data_payload_i (rsp_pl_in),
    .credit_valid_i (rsp_cv_in),
    .credit_id_i    (rsp_cid_in),
    .data_valid_o   (rsp_v_out),
    .data_hdr_o     (rsp_hdr_out),
    .data_payload_o (rsp_pl_out),
    .credit_valid_o (rsp_cv_out),
    .credit_id_o    (rsp_cid_out)
  );

  vc_router #(
    .PayloadWidth (WidePayloadWidth)
  ) i_wide_vc_router (
    .clk_i,
    .rst_n_i,
    .tile_id_i,
    .data_valid_i   (wide_v_in),
    .data_hdr_i     (wide_hdr_in),
    .data_payload_i (wide_pl_in),
    .credit_valid_i (wide_cv_in),
    .credit_id_i    (wide_cid_in),
    .data_valid_o   (wide_v_out),
    .data_hdr_o     (wide_hdr_out),
    .data_payload_o (wide_pl_out),
    .credit_valid_o (wide_cv_out),
    .credit_id_o    (wide_cid_out)
  );

endmodule

/* noc_router_pkg.sv */
// Shared constants and link types for a mesh of at most 4x4 tiles with two VCs of depth two
package noc_router_pkg;

  localparam int NumPorts = 5;

  // Port indices, also the order of every port array
  localparam int PortN = 0;
  localparam int PortE = 1;
  localparam int PortS = 2;
  localparam int PortW = 3;
  localparam int PortL = 4;

  localparam int NumVc = 2;

  // Slots per VC buffer and the reset value of each downstream credit counter
  localparam int VcDepth = 2;
  localparam int VcPtrWidth = (VcDepth > 1) ? $clog2(VcDepth) : 1;
  localparam int CreditWidth = $clog2(VcDepth + 1);

  localparam int CoordWidth = 2;
  localparam int NarrowPayloadWidth = 32;
  localparam int WidePayloadWidth = 128;

  typedef logic [$clog2(NumVc)-1:0] vc_id_t;
  typedef logic [2:0] port_sel_t;

  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } coord_t;

  // The VC id is kept unchanged on every hop
  typedef struct packed {
    coord_t dst;
    vc_id_t vc_id;
    logic   last;
  } flit_hdr_t;

  // Flit fields come from upstream, credit fields go back to that same neighbour
  typedef struct packed {
    logic                          valid;
    flit_hdr_t                     hdr;
    logic [NarrowPayloadWidth-1:0] payload;
    logic                          credit_v;
    vc_id_t                        credit_id;
  } req_link_t;

  typedef struct packed {
    logic                          valid;
    flit_hdr_t                     hdr;
    logic [NarrowPayloadWidth-1:0] payload;
    logic                          credit_v;
    vc_id_t                        credit_id;
  } rsp_link_t;

  typedef struct packed {
    logic                        valid;
    flit_hdr_t                   hdr;
    logic [WidePayloadWidth-1:0] payload;
    logic                        credit_v;
    vc_id_t                      credit_id;
  } wide_link_t;

endpackage

/* output_port_alloc.sv */
// Round-robin switch allocator for one output; the scan pointer starts at port 0 after reset
module output_port_alloc #(
  parameter int unsigned PayloadWidth = noc_router_pkg::NarrowPayloadWidth
) (
  input  logic                                                                  clk_i,
  input  logic                                                                  rst_n_i,
  input  logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::NumVc-1:0]        req_i,
  input  noc_router_pkg::flit_hdr_t
           [noc_router_pkg::NumPorts-1:0][noc_router_pkg::NumVc-1:0]            head_hdr_i,
  input  logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::NumVc-1:0]
           [PayloadWidth-1:0]                                                   head_payload_i,
  input  logic                                                                  credit_v_i,
  input  noc_router_pkg::vc_id_t                                                credit_id_i,
  output logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::NumVc-1:0]        grant_o,
  output logic                                                                  valid_o,
  output noc_router_pkg::flit_hdr_t                                             hdr_o,
  output logic [PayloadWidth-1:0]                                               payload_o
);
  import noc_router_pkg::*;

  logic [NumVc-1:0][CreditWidth-1:0] credit_q;
  logic [NumPorts-1:0][NumVc-1:0]    req_masked;
  port_sel_t                         rr_ptr_q;
  port_sel_t                         win_port;
  vc_id_t                            win_vc;
  logic                              win_v;
  logic                              valid_q;
  flit_hdr_t                         hdr_q;
  logic [PayloadWidth-1:0]           payload_q;

  // A VC without downstream credit cannot compete
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVc; v++) begin
        req_masked[p][v] = req_i[p][v] && (credit_q[v] != '0);
      end
    end
  end

  // Input scan begins at rr_ptr_q, then the lowest requesting VC of that input wins
  always_comb begin
    int idx;
    win_v    = 1'b0;
    win_port = '0;
    win_vc   = '0;
    for (int i = 0; i < NumPorts; i++) begin
      idx = (int'(rr_ptr_q) + i) % NumPorts;
      if (!win_v && (req_masked[idx] != '0)) begin
        win_v    = 1'b1;
        win_port = port_sel_t'(idx);
      end
    end
    for (int v = NumVc - 1; v >= 0; v--) begin
      if (req_masked[win_port][v]) begin
        win_vc = vc_id_t'(v);
      end
    end
  end

  always_comb begin
    grant_o = '0;
    if (win_v) begin
      grant_o[win_port][win_vc] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < NumVc; v++) begin
        credit_q[v] <= CreditWidth'(VcDepth);
      end
      rr_ptr_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      for (int v = 0; v < NumVc; v++) begin
        credit_q[v] <= credit_q[v]
                       - CreditWidth'(win_v && (win_vc == vc_id_t'(v)))
                       + CreditWidth'(credit_v_i && (credit_id_i == vc_id_t'(v)));
      end
      valid_q <= win_v;
      // Next scan starts just after the winner
      if (win_v) begin
        rr_ptr_q <= (win_port == port_sel_t'(NumPorts - 1)) ? '0 : win_port + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (win_v) begin
      hdr_q     <= head_hdr_i[win_port][win_vc];
      payload_q <= head_payload_i[win_port][win_vc];
    end
  end

  assign valid_o   = valid_q;
  assign hdr_o     = hdr_q;
  assign payload_o = payload_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator; exits 1 on build error or reported failure
verilator --binary --top-module tb_narrow_wide_router -f narrow_wide_router.f \
  -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 || { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

/* tb_narrow_wide_router.sv */
// Tile sits at (1,1); the testbench acts as every neighbour and returns downstream credits itself
module tb_narrow_wide_router;
  import noc_router_pkg::*;

  localparam int     Timeout = 100;
  localparam int     NumRows = 16;
  localparam int     NumQ    = 3 * NumPorts;
  localparam coord_t TileId  = '{x: 2'd1, y: 2'd1};

  typedef struct packed {
    logic [1:0] net;
    port_sel_t  port;
    vc_id_t     vc;
    coord_t     dst;
    logic [1:0] hold;
    logic       rel;
    port_sel_t  out;
    logic       lat;
    logic [7:0] grp;
  } row_t;

  typedef struct packed {
    logic                        lat;
    logic [31:0]                 sent;
    flit_hdr_t                   hdr;
    logic [WidePayloadWidth-1:0] payload;
  } exp_flit_t;

  // Columns are net (0 req, 1 rsp, 2 wide), in port, VC, dst {x,y}, withheld credits,
  // release, expected out port, latency check, group; ports are N0 E1 S2 W3 L4
  localparam row_t Rows [NumRows] = '{
    '{2'd0, 3'd4, 1'b0, '{2'd2, 2'd1}, 2'd0, 1'b0, 3'd1, 1'b1, 8'd0},
    '{2'd0, 3'd4, 1'b1, '{2'd0, 2'd1}, 2'd0, 1'b0, 3'd3, 1'b1, 8'd1},
    '{2'd1, 3'd0, 1'b0, '{2'd1, 2'd2}, 2'd0, 1'b0, 3'd0, 1'b1, 8'd2},
    '{2'd1, 3'd3, 1'b1, '{2'd1, 2'd0}, 2'd0, 1'b0, 3'd2, 1'b1, 8'd3},
    '{2'd2, 3'd1, 1'b0, '{2'd1, 2'd1}, 2'd0, 1'b0, 3'd4, 1'b1, 8'd4},
    '{2'd2, 3'd2, 1'b1, '{2'd3, 2'd2}, 2'd0, 1'b0, 3'd1, 1'b1, 8'd5},
    '{2'd0, 3'd4, 1'b0, '{2'd2, 2'd0}, 2'd2, 1'b0, 3'd1, 1'b0, 8'd6},
    '{2'd0, 3'd4, 1'b0, '{2'd2, 2'd0}, 2'd0, 1'b0, 3'd1, 1'b0, 8'd7},
    '{2'd0, 3'd4, 1'b0, '{2'd3, 2'd3}, 2'd0, 1'b0, 3'd1, 1'b0, 8'd8},
    '{2'd0, 3'd4, 1'b0, '{2'd2, 2'd2}, 2'd0, 1'b0, 3'd1, 1'b0, 8'd9},
    '{2'd0, 3'd4, 1'b0, '{2'd0, 2'd0}, 2'd0, 1'b1, 3'd1, 1'b0, 8'd10},
    '{2'd1, 3'd1, 1'b0, '{2'd0, 2'd1}, 2'd0, 1'b0, 3'd3, 1'b0, 8'd11},
    '{2'd1, 3'd2, 1'b0, '{2'd0, 2'd2}, 2'd0, 1'b0, 3'd3, 1'b0, 8'd11},
    '{2'd0, 3'd0, 1'b1, '{2'd1, 2'd0}, 2'd0, 1'b0, 3'd2, 1'b0, 8'd12},
    '{2'd1, 3'd0, 1'b1, '{2'd1, 2'd0}, 2'd0, 1'b0, 3'd2, 1'b0, 8'd12},
    '{2'd2, 3'd0, 1'b1, '{2'd1, 2'd0}, 2'd0, 1'b0, 3'd2, 1'b0, 8'd12}
  };

  logic clk_i = 1'b0;
  logic rst_n_i;

  req_link_t  [NumPorts-1:0] req_i;
  req_link_t  [NumPorts-1:0] req_o;
  rsp_link_t  [NumPorts-1:0] rsp_i;
  rsp_link_t  [NumPorts-1:0] rsp_o;
  wide_link_t [NumPorts-1:0] wide_i;
  wide_link_t [NumPorts-1:0] wide_o;

  // Per network and port views of the three link bundles
  logic                        in_v   [3][NumPorts];
  flit_hdr_t                   in_hdr [3][NumPorts];
  logic [WidePayloadWidth-1:0] in_pl  [3][NumPorts];
  logic                        dn_cv  [3][NumPorts];
  vc_id_t                      dn_cid [3][NumPorts];
  logic                        out_v  [3][NumPorts];
  flit_hdr_t                   out_hdr[3][NumPorts];
  logic [WidePayloadWidth-1:0] out_pl [3][NumPorts];
  logic                        cv_o   [3][NumPorts];
  vc_id_t                      cid_o  [3][NumPorts];

  exp_flit_t   exp_q     [NumQ][$];
  int          up_got    [NumQ][NumVc];
  int          up_used   [NumQ][NumVc];
  int          dn_cred   [NumQ][NumVc];
  int          held      [NumQ][NumVc];
  int          hold_left [NumQ];
  logic        release_q [NumQ];
  int          crd_due   [NumQ];
  vc_id_t      crd_vc    [NumQ];
  int          cyc;
  int          mis_cnt;
  int          oth_cnt;
  logic        aborted;
  logic [31:0] lfsr;

  always #4 clk_i = ~clk_i;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_link
    assign req_i[p]  = '{in_v[0][p], in_hdr[0][p], in_pl[0][p][NarrowPayloadWidth-1:0],
                         dn_cv[0][p], dn_cid[0][p]};
    assign rsp_i[p]  = '{in_v[1][p], in_hdr[1][p], in_pl[1][p][NarrowPayloadWidth-1:0],
                         dn_cv[1][p], dn_cid[1][p]};
    assign wide_i[p] = '{in_v[2][p], in_hdr[2][p], in_pl[2][p], dn_cv[2][p], dn_cid[2][p]};
    assign out_v[0][p]   = req_o[p].valid;
    assign out_hdr[0][p] = req_o[p].hdr;
    assign out_pl[0][p]  = WidePayloadWidth'(req_o[p].payload);
    assign cv_o[0][p]    = req_o[p].credit_v;
    assign cid_o[0][p]   = req_o[p].credit_id;
    assign out_v[1][p]   = rsp_o[p].valid;
    assign out_hdr[1][p] = rsp_o[p].hdr;
    assign out_pl[1][p]  = WidePayloadWidth'(rsp_o[p].payload);
    assign cv_o[1][p]    = rsp_o[p].credit_v;
    assign cid_o[1][p]   = rsp_o[p].credit_id;
    assign out_v[2][p]   = wide_o[p].valid;
    assign out_hdr[2][p] = wide_o[p].hdr;
    assign out_pl[2][p]  = wide_o[p].payload;
    assign cv_o[2][p]    = wide_o[p].credit_v;
    assign cid_o[2][p]   = wide_o[p].credit_id;
  end

  narrow_wide_router i_narrow_wide_router (
    .clk_i,
    .rst_n_i,
    .tile_id_i (TileId),
    .req_i,
    .req_o,
    .rsp_i,
    .rsp_o,
    .wide_i,
    .wide_o
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic make_payload(input int width, output logic [WidePayloadWidth-1:0] pl);
    pl = '0;
    for (int i = 0; i < width; i++) begin
      lfsr  = lfsr_next(lfsr);
      pl[i] = lfsr[0];
    end
  endtask

  // Takes one received flit, compares it and returns or withholds its credit
  task automatic take_flit(input int n, input int p, input int idx);
    exp_flit_t e;
    vc_id_t    v;
    if (exp_q[idx].size() == 0) begin
      $display("unexpected flit on network %0d output %0d", n, p);
      oth_cnt++;
      return;
    end
    e = exp_q[idx].pop_front();
    v = out_hdr[n][p].vc_id;
    if (out_hdr[n][p] != e.hdr) begin
      $display("mismatch hdr net %0d port %0d: got %h expected %h", n, p, out_hdr[n][p], e.hdr);
      mis_cnt++;
    end
    if (out_pl[n][p] != e.payload) begin
      $display("mismatch payload net %0d port %0d: got %h expected %h",
               n, p, out_pl[n][p], e.payload);
      mis_cnt++;
    end
    if (e.lat && (cyc - int'(e.sent) != 2)) begin
      $display("mismatch latency net %0d port %0d: got %h expected %h", n, p,
               cyc - int'(e.sent), 2);
      mis_cnt++;
    end
    if (dn_cred[idx][v] == 0) begin
      $display("flit left network %0d output %0d without a downstream credit", n, p);
      oth_cnt++;
    end else begin
      dn_cred[idx][v]--;
    end
    if (hold_left[idx] > 0) begin
      hold_left[idx]--;
      held[idx][v]++;
    end else begin
      dn_cv[n][p]  = 1'b1;
      dn_cid[n][p] = v;
      dn_cred[idx][v]++;
    end
  endtask

  // Advances to the next falling edge and services every output
  task automatic step();
    int idx;
    @(negedge clk_i);
    cyc++;
    for (int n = 0; n < 3; n++) begin
      for (int p = 0; p < NumPorts; p++) begin
        idx = n * NumPorts + p;
        dn_cv[n][p] = 1'b0;
        if (cv_o[n][p]) begin
          up_got[idx][cid_o[n][p]]++;
        end
        if (crd_due[idx] == cyc) begin
          if (!cv_o[n][p] || (cid_o[n][p] != crd_vc[idx])) begin
            $display("mismatch credit_v/credit_id net %0d port %0d: got %h/%h expected 1/%h",
                     n, p, cv_o[n][p], cid_o[n][p], crd_vc[idx]);
            mis_cnt++;
          end
        end
        if (out_v[n][p]) begin
          take_flit(n, p, idx);
        end else if (release_q[idx]) begin
          for (int v = 0; v < NumVc; v++) begin
            if (!dn_cv[n][p] && (held[idx][v] > 0)) begin
              held[idx][v]--;
              dn_cred[idx][v]++;
              dn_cv[n][p]  = 1'b1;
              dn_cid[n][p] = vc_id_t'(v);
            end
          end
        end
      end
    end
  endtask

  function automatic logic credits_ready(input int r0, input int r1);
    int idx;
    for (int r = r0; r < r1; r++) begin
      idx = int'(Rows[r].net) * NumPorts + int'(Rows[r].port);
      if (!Rows[r].rel &&
          (VcDepth + up_got[idx][Rows[r].vc] - up_used[idx][Rows[r].vc] <= 0)) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Settled when every queue is empty or its head waits for a withheld credit
  function automatic logic drained();
    for (int i = 0; i < NumQ; i++) begin
      if ((exp_q[i].size() != 0) && (dn_cred[i][exp_q[i][0].hdr.vc_id] != 0)) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic apply_group(input int r0, input int r1);
    int                          t;
    int                          oi;
    int                          ii;
    flit_hdr_t                   hdr;
    logic [WidePayloadWidth-1:0] pl;
    for (int r = r0; r < r1; r++) begin
      oi = int'(Rows[r].net) * NumPorts + int'(Rows[r].out);
      if (Rows[r].rel) begin
        repeat (6) step();
        if (exp_q[oi].size() != VcDepth) begin
          $display("mismatch held flits net %0d port %0d: got %h expected %h",
                   Rows[r].net, Rows[r].out, exp_q[oi].size(), VcDepth);
          mis_cnt++;
        end
        release_q[oi] = 1'b1;
      end else if (Rows[r].hold != 0) begin
        hold_left[oi] = int'(Rows[r].hold);
      end
    end
    step();
    t = 0;
    while (!credits_ready(r0, r1) && (t < Timeout)) begin
      step();
      t++;
    end
    if (t >= Timeout) begin
      $display("timed out waiting for an upstream credit in group %0d", Rows[r0].grp);
      oth_cnt++;
      aborted = 1'b1;
      return;
    end
    for (int r = r0; r < r1; r++) begin
      if (!Rows[r].rel) begin
        ii  = int'(Rows[r].net) * NumPorts + int'(Rows[r].port);
        oi  = int'(Rows[r].net) * NumPorts + int'(Rows[r].out);
        // The last flag alternates by row so both values cross the router
        hdr = '{Rows[r].dst, Rows[r].vc, r[0]};
        make_payload((int'(Rows[r].net) == 2) ? WidePayloadWidth : NarrowPayloadWidth, pl);
        in_v[Rows[r].net][Rows[r].port]   = 1'b1;
        in_hdr[Rows[r].net][Rows[r].port] = hdr;
        in_pl[Rows[r].net][Rows[r].port]  = pl;
        up_used[ii][Rows[r].vc]++;
        exp_q[oi].push_back('{Rows[r].lat, 32'(cyc), hdr, pl});
        if (Rows[r].lat) begin
          crd_due[ii] = cyc + 2;
          crd_vc[ii]  = Rows[r].vc;
        end
      end
    end
    step();
    for (int r = r0; r < r1; r++) begin
      in_v[Rows[r].net][Rows[r].port] = 1'b0;
    end
  endtask

  task automatic drain();
    int t;
    t = 0;
    while (!drained() && (t < Timeout)) begin
      step();
      t++;
    end
    if (t >= Timeout) begin
      $display("timed out waiting for expected flits to leave the router");
      oth_cnt++;
      aborted = 1'b1;
    end
  endtask

  initial begin
    int r;
    int r1;
    rst_n_i = 1'b0;
    lfsr    = 32'h9cda;
    cyc     = 0;
    mis_cnt = 0;
    oth_cnt = 0;
    aborted = 1'b0;
    for (int n = 0; n < 3; n++) begin
      for (int p = 0; p < NumPorts; p++) begin
        in_v[n][p]   = 1'b0;
        in_hdr[n][p] = '0;
        in_pl[n][p]  = '0;
        dn_cv[n][p]  = 1'b0;
        dn_cid[n][p] = '0;
      end
    end
    for (int i = 0; i < NumQ; i++) begin
      hold_left[i] = 0;
      release_q[i] = 1'b0;
      crd_due[i]   = -1;
      crd_vc[i]    = '0;
      for (int v = 0; v < NumVc; v++) begin
        up_got[i][v]  = 0;
        up_used[i][v] = 0;
        dn_cred[i][v] = VcDepth;
        held[i][v]    = 0;
      end
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    r = 0;
    while ((r < NumRows) && !aborted) begin
      r1 = r;
      while ((r1 < NumRows) && (Rows[r1].grp == Rows[r].grp)) begin
        r1++;
      end
      apply_group(r, r1);
      if (!aborted) begin
        drain();
      end
      r = r1;
    end
    for (int i = 0; i < NumQ; i++) begin
      if (exp_q[i].size() != 0) begin
        $display("%0d flits never left network %0d output %0d",
                 exp_q[i].size(), i / NumPorts, i % NumPorts);
        oth_cnt++;
      end
    end
    $display("errors: %0d mismatches, %0d other failures", mis_cnt, oth_cnt);
    if ((mis_cnt + oth_cnt) == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* vc_input_port.sv */
// VC input buffers with XY routing; upstream must never send a flit without a credit for its VC
module vc_input_port #(
  parameter int unsigned PayloadWidth = noc_router_pkg::NarrowPayloadWidth
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  noc_router_pkg::coord_t                                tile_id_i,
  input  logic                                                  valid_i,
  input  noc_router_pkg::flit_hdr_t                             hdr_i,
  input  logic [PayloadWidth-1:0]                               payload_i,
  input  logic [noc_router_pkg::NumVc-1:0]                      pop_i,
  output logic [noc_router_pkg::NumVc-1:0]                      head_valid_o,
  output noc_router_pkg::flit_hdr_t [noc_router_pkg::NumVc-1:0] head_hdr_o,
  output logic [noc_router_pkg::NumVc-1:0][PayloadWidth-1:0]    head_payload_o,
  output noc_router_pkg::port_sel_t [noc_router_pkg::NumVc-1:0] route_o,
  output logic                                                  credit_v_o,
  output noc_router_pkg::vc_id_t                                credit_id_o
);
  import noc_router_pkg::*;

  logic [NumVc-1:0]                  push;
  logic [NumVc-1:0][CreditWidth-1:0] owed_q;
  logic [NumVc-1:0][CreditWidth-1:0] avail;
  logic                              ret_v;
  vc_id_t                            ret_id;
  logic                              credit_v_q;
  vc_id_t                            credit_id_q;

  for (genvar v = 0; v < NumVc; v++) begin : gen_vc
    flit_hdr_t               hdr_mem     [VcDepth];
    logic [PayloadWidth-1:0] payload_mem [VcDepth];
    logic [VcPtrWidth-1:0]   rd_ptr_q;
    logic [VcPtrWidth-1:0]   wr_ptr_q;
    logic [CreditWidth-1:0]  count_q;

    assign push[v] = valid_i && (hdr_i.vc_id == vc_id_t'(v));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push[v]) begin
          wr_ptr_q <= (wr_ptr_q == VcPtrWidth'(VcDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop_i[v]) begin
          rd_ptr_q <= (rd_ptr_q == VcPtrWidth'(VcDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        count_q <= count_q + CreditWidth'(push[v]) - CreditWidth'(pop_i[v]);
      end
    end

    always_ff @(posedge clk_i) begin
      if (push[v]) begin
        hdr_mem[wr_ptr_q]     <= hdr_i;
        payload_mem[wr_ptr_q] <= payload_i;
      end
    end

    assign head_valid_o[v]   = (count_q != '0);
    assign head_hdr_o[v]     = hdr_mem[rd_ptr_q];
    assign head_payload_o[v] = payload_mem[rd_ptr_q];

    // X is resolved before Y, so a flit turns at most once
    always_comb begin
      if (head_hdr_o[v].dst.x > tile_id_i.x) begin
        route_o[v] = port_sel_t'(PortE);
      end else if (head_hdr_o[v].dst.x < tile_id_i.x) begin
        route_o[v] = port_sel_t'(PortW);
      end else if (head_hdr_o[v].dst.y > tile_id_i.y) begin
        route_o[v] = port_sel_t'(PortN);
      end else if (head_hdr_o[v].dst.y < tile_id_i.y) begin
        route_o[v] = port_sel_t'(PortS);
      end else begin
        route_o[v] = port_sel_t'(PortL);
      end
    end
  end

  // Two outputs may pop two VCs in one cycle but only one credit leaves per cycle
  // Lowest VC with an unreturned slot goes first
  always_comb begin
    ret_v  = 1'b0;
    ret_id = '0;
    for (int v = NumVc - 1; v >= 0; v--) begin
      avail[v] = owed_q[v] + CreditWidth'(pop_i[v]);
      if (avail[v] != '0) begin
        ret_v  = 1'b1;
        ret_id = vc_id_t'(v);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owed_q      <= '0;
      credit_v_q  <= 1'b0;
      credit_id_q <= '0;
    end else begin
      for (int v = 0; v < NumVc; v++) begin
        owed_q[v] <= avail[v] - CreditWidth'(ret_v && (ret_id == vc_id_t'(v)));
      end
      credit_v_q  <= ret_v;
      credit_id_q <= ret_id;
    end
  end

  assign credit_v_o  = credit_v_q;
  assign credit_id_o = credit_id_q;

endmodule

/* vc_router.sv */
// Five-port VC router for one network; minimum latency is two cycles from input to output
module vc_router #(
  parameter int unsigned PayloadWidth = noc_router_pkg::NarrowPayloadWidth
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  noc_router_pkg::coord_t                                   tile_id_i,
  input  logic [noc_router_pkg::NumPorts-1:0]                      data_valid_i,
  input  noc_router_pkg::flit_hdr_t [noc_router_pkg::NumPorts-1:0] data_hdr_i,
  input  logic [noc_router_pkg::NumPorts-1:0][PayloadWidth-1:0]    data_payload_i,
  input  logic [noc_router_pkg::NumPorts-1:0]                      credit_valid_i,
  input  noc_router_pkg::vc_id_t [noc_router_pkg::NumPorts-1:0]    credit_id_i,
  output logic [noc_router_pkg::NumPorts-1:0]                      data_valid_o,
  output noc_router_pkg::flit_hdr_t [noc_router_pkg::NumPorts-1:0] data_hdr_o,
  output logic [noc_router_pkg::NumPorts-1:0][PayloadWidth-1:0]    data_payload_o,
  output logic [noc_router_pkg::NumPorts-1:0]                      credit_valid_o,
  output noc_router_pkg::vc_id_t [noc_router_pkg::NumPorts-1:0]    credit_id_o
);
  import noc_router_pkg::*;

  logic      [NumPorts-1:0][NumVc-1:0]                   head_valid;
  flit_hdr_t [NumPorts-1:0][NumVc-1:0]                   head_hdr;
  logic      [NumPorts-1:0][NumVc-1:0][PayloadWidth-1:0] head_payload;
  port_sel_t [NumPorts-1:0][NumVc-1:0]                   route;
  logic      [NumPorts-1:0][NumVc-1:0]                   pop;
  // Indexed as output, input, VC
  logic      [NumPorts-1:0][NumPorts-1:0][NumVc-1:0]     out_req;
  logic      [NumPorts-1:0][NumPorts-1:0][NumVc-1:0]     out_grant;

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        for (int v = 0; v < NumVc; v++) begin
          out_req[o][i][v] = head_valid[i][v] && (route[i][v] == port_sel_t'(o));
        end
      end
    end
  end

  // Grants from all outputs pop the granted heads
  always_comb begin
    pop = '0;
    for (int o = 0; o < NumPorts; o++) begin
      pop = pop | out_grant[o];
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    vc_input_port #(
      .PayloadWidth (PayloadWidth)
    ) i_vc_input_port (
      .clk_i,
      .rst_n_i,
      .tile_id_i,
      .valid_i        (data_valid_i[p]),
      .hdr_i          (data_hdr_i[p]),
      .payload_i      (data_payload_i[p]),
      .pop_i          (pop[p]),
      .head_valid_o   (head_valid[p]),
      .head_hdr_o     (head_hdr[p]),
      .head_payload_o (head_payload[p]),
      .route_o        (route[p]),
      .credit_v_o     (credit_valid_o[p]),
      .credit_id_o    (credit_id_o[p])
    );

    // Credits for output p arrive on the input link of the same port
    output_port_alloc #(
      .PayloadWidth (PayloadWidth)
    ) i_output_port_alloc (
      .clk_i,
      .rst_n_i,
      .req_i          (out_req[p]),
      .head_hdr_i     (head_hdr),
      .head_payload_i (head_payload),
      .credit_v_i     (credit_valid_i[p]),
      .credit_id_i    (credit_id_i[p]),
      .grant_o        (out_grant[p]),
      .valid_o        (data_valid_o[p]),
      .hdr_o          (data_hdr_o[p]),
      .payload_o      (data_payload_o[p])
    );
  end

endmodule
